// File: src/conPkg.sv
package conPkg;

  localparam int condWidth     = 6;
  localparam int magicWidth    = 9;
  localparam int diagSelWidth  = 3;
  localparam int ebusDiagWidth = 7;

  // Group select in the upper three condition bits
  localparam logic [2:0] condEn10 = 3'd1;
  localparam logic [2:0] condEn20 = 3'd2;
  localparam logic [2:0] condEn30 = 3'd3;
  localparam logic [2:0] skipEn60 = 3'd6;
  localparam logic [2:0] skipEn70 = 3'd7;

  localparam logic [2:0] condLoadIr    = 3'd4;
  localparam logic [2:0] condSpecInstr = 3'd5;
  localparam logic [2:0] condSrMagic   = 3'd6;
  localparam logic [2:0] condSelVma    = 3'd7;

  localparam logic [2:0] condDiagFunc = 3'd0;
  localparam logic [2:0] condEbusCtl  = 3'd2;

  // Magic function 01x and its CONO sub-codes
  localparam logic [2:0] funcCono    = 3'd1;
  localparam logic [2:0] conoAprCode = 3'd4;
  localparam logic [2:0] conoPiCode  = 3'd5;
  localparam logic [2:0] conoPagCode = 3'd6;

  // Magic bit 0 is the MSB
  typedef union packed {
    struct packed {
      logic [1:0] funcSpare;
      logic       funcExt;
      logic [2:0] funcGroup;
      logic [2:0] funcSub;
    } funcView;
    struct packed {
      logic piCycleSet;
      logic kernelCycle;
      logic pcInhibit;
      logic spare3;
      logic pxct;
      logic intDisable;
      logic spare6;
      logic haltReq;
      logic spare8;
    } flagView;
  } magicWord;

endpackage

// File: src/condDecode.sv
`timescale 1ns/1ns

module condDecode #(
  parameter int condW = conPkg::condWidth
) (
  input  logic             conCLK,
  input  logic             CLK,
  input  logic [condW-1:0] crCond,
  output logic             condLoadIr,
  output logic             condSpecInstr,
  output logic             condSrMagic,
  output logic             condSelVma,
  output logic             condDiagFunc,
  output logic             condEbusCtl,
  output logic             vmaMagic,
  output logic             skipGroup6,
  output logic             skipGroup7
);

  logic [2:0] groupSel;
  logic [2:0] codeSel;
  logic       en10;
  logic       en20;
  logic       en30;
  logic       vmaMagicNext;

  assign groupSel = crCond[condW-1 -: 3];
  assign codeSel  = crCond[2:0];

  // Whole decoder is disabled while in reset
  always_comb begin
    en10       = !CLK && groupSel == conPkg::condEn10;
    en20       = !CLK && groupSel == conPkg::condEn20;
    en30       = !CLK && groupSel == conPkg::condEn30;
    skipGroup6 = !CLK && groupSel == conPkg::skipEn60;
    skipGroup7 = !CLK && groupSel == conPkg::skipEn70;
  end

  always_comb begin
    condLoadIr    = en10 && codeSel == conPkg::condLoadIr;
    condSpecInstr = en10 && codeSel == conPkg::condSpecInstr;
    condSrMagic   = en10 && codeSel == conPkg::condSrMagic;
    condSelVma    = en10 && codeSel == conPkg::condSelVma;
    condDiagFunc  = en20 && codeSel == conPkg::condDiagFunc;
    condEbusCtl   = en20 && codeSel == conPkg::condEbusCtl;
  end

  // Codes 30 to 34 are the VMA magic group
  assign vmaMagicNext = en30 && codeSel < 3'd5;

  // Held one cycle for diagnostic readback
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      vmaMagic <= 1'b0;
    end else begin
      vmaMagic <= vmaMagicNext;
    end
  end

endmodule

// File: src/magicFuncDecode.sv
`timescale 1ns/1ns

module magicFuncDecode #(
  parameter int magicW = conPkg::magicWidth,
  parameter int ebusW  = conPkg::ebusDiagWidth
) (
  input  logic              conCLK,
  input  logic              CLK,
  input  logic [magicW-1:0] crMagic,
  input  logic              condDiagFunc,
  input  logic              ebusSync,
  input  logic [ebusW-1:0]  ebusData,
  output logic              conoApr,
  output logic              conoPi,
  output logic              conoPag,
  output logic              cacheLookEn,
  output logic              cacheLoadEn,
  output logic              trapEn,
  output logic              kiPagingMode,
  output logic [2:0]        parWrBits
);

  conPkg::magicWord magic;
  logic             funcHit;

  assign magic = crMagic;

  // Function 01x, only with magic bit 2 clear
  assign funcHit = condDiagFunc && !magic.funcView.funcExt &&
                   magic.funcView.funcGroup == conPkg::funcCono;

  always_comb begin
    conoApr = ebusSync && funcHit && magic.funcView.funcSub == conPkg::conoAprCode;
    conoPi  = ebusSync && funcHit && magic.funcView.funcSub == conPkg::conoPiCode;
    conoPag = funcHit && magic.funcView.funcSub == conPkg::conoPagCode;
  end

  // ebusData MSB is bus bit 18
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      cacheLookEn  <= 1'b0;
      cacheLoadEn  <= 1'b0;
      kiPagingMode <= 1'b0;
      trapEn       <= 1'b0;
    end else if (conoPag) begin
      cacheLookEn  <= ebusData[ebusW-1];
      cacheLoadEn  <= ebusData[ebusW-2];
      // Bit 21 enables KL paging
      kiPagingMode <= !ebusData[ebusW-4];
      trapEn       <= ebusData[ebusW-5];
    end
  end

  // Write-even-parity for address, data and directory
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      parWrBits <= 3'b000;
    end else if (conoPi) begin
      parWrBits <= ebusData[ebusW-1 -: 3];
    end
  end

endmodule

// File: src/cycleState.sv
`timescale 1ns/1ns

module cycleState #(
  parameter int magicW = conPkg::magicWidth
) (
  input  logic              conCLK,
  input  logic              CLK,
  input  logic [magicW-1:0] crMagic,
  input  logic              condSpecInstr,
  input  logic              condLoadIr,
  input  logic              mboxCycReq,
  input  logic              vmaFetch,
  input  logic              vmaAcRef,
  input  logic              mbXfer,
  input  logic              pageError,
  input  logic              skipSatisfied,
  input  logic              userMode,
  input  logic              publicMode,
  output logic              memCycle,
  output logic              piCycle,
  output logic              mboxWait,
  output logic              loadIr,
  output logic              kernelMode,
  output logic              kernelCycle,
  output logic              pxct,
  output logic              intDisable
);

  conPkg::magicWord magic;
  logic             fetchCycle;

  assign magic = crMagic;

  // Special-instruction flags
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      kernelCycle <= 1'b0;
      pxct        <= 1'b0;
      intDisable  <= 1'b0;
    end else if (condSpecInstr) begin
      kernelCycle <= magic.flagView.kernelCycle;
      pxct        <= magic.flagView.pxct;
      intDisable  <= magic.flagView.intDisable;
    end
  end

  // PI cycle ends when the skip is satisfied
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      piCycle <= 1'b0;
    end else if (condSpecInstr) begin
      piCycle <= magic.flagView.piCycleSet;
    end else if (skipSatisfied) begin
      piCycle <= 1'b0;
    end
  end

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      memCycle <= 1'b0;
    end else begin
      memCycle <= mboxCycReq || (memCycle && !mbXfer && !pageError);
    end
  end

  always_comb begin
    // AC references come from fast memory, so no MBOX wait
    mboxWait   = memCycle && !vmaAcRef;
    fetchCycle = vmaFetch && memCycle;
    loadIr     = fetchCycle || condLoadIr;
    kernelMode = !userMode && !publicMode;
  end

endmodule

// File: src/runControl.sv
`timescale 1ns/1ns

module runControl #(
  parameter int selW = conPkg::diagSelWidth
) (
  input  logic            conCLK,
  input  logic            CLK,
  input  logic            diagCtlFunc01x,
  input  logic [selW-1:0] diagDs,
  output logic            run,
  output logic            start
);

  logic       clrRun;
  logic       setRun;
  logic       contStrobe;
  logic [1:0] runPipe;
  logic [1:0] startPipe;

  // Diagnostic function 01x, data select 0 to 2
  always_comb begin
    clrRun     = diagCtlFunc01x && diagDs == selW'(0);
    setRun     = diagCtlFunc01x && diagDs == selW'(1);
    contStrobe = diagCtlFunc01x && diagDs == selW'(2);
  end

  // First stage is the run flop itself, two more to sync
  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      runPipe   <= 2'b00;
      run       <= 1'b0;
      startPipe <= 2'b00;
      start     <= 1'b0;
    end else begin
      if (setRun) begin
        runPipe[0] <= 1'b1;
      end else if (clrRun) begin
        runPipe[0] <= 1'b0;
      end
      runPipe[1] <= runPipe[0];
      run        <= runPipe[1];
      startPipe  <= {startPipe[0], contStrobe};
      start      <= startPipe[1];
    end
  end

endmodule

// File: src/skipSelect.sv
`timescale 1ns/1ns

module skipSelect #(
  parameter int condW = conPkg::condWidth
) (
  input  logic             conCLK,
  input  logic             CLK,
  input  logic [condW-1:0] crCond,
  input  logic             skipGroup6,
  input  logic             skipGroup7,
  input  logic             vmaFetch,
  input  logic             kernelMode,
  input  logic             userMode,
  input  logic             publicMode,
  input  logic             piCycle,
  input  logic             run,
  input  logic             start,
  input  logic             pxct,
  input  logic             kernelCycle,
  input  logic             intDisable,
  input  logic             irIoLegal,
  input  logic             userIot,
  input  logic             vmaAcRef,
  input  logic             mtrIntReq,
  input  logic             piReady,
  output logic             condAdr10
);

  logic       mtrIntReqReg;
  logic       piReadyReg;
  logic       intReq;
  logic       ioLegal;
  logic [7:0] skip6x;
  logic [7:0] skip7x;

  always_ff @(posedge conCLK or posedge CLK) begin
    if (CLK) begin
      mtrIntReqReg <= 1'b0;
      piReadyReg   <= 1'b0;
    end else begin
      mtrIntReqReg <= mtrIntReq;
      piReadyReg   <= piReady;
    end
  end

  always_comb begin
    intReq  = (mtrIntReqReg || piReadyReg) && !intDisable;
    ioLegal = irIoLegal || kernelMode || kernelCycle || (userMode && userIot);
  end

  // Index is the low condition digit
  always_comb begin
    skip6x = {1'b0, 1'b0, piCycle, 1'b0, publicMode, userMode, kernelMode, vmaFetch};
    // Entry 5 is section 0, always true on a single-section machine
    skip7x = {!mtrIntReqReg, vmaAcRef, 1'b1, pxct, ioLegal, run, !start, intReq};
  end

  assign condAdr10 = (skipGroup6 && skip6x[crCond[2:0]]) ||
                     (skipGroup7 && skip7x[crCond[2:0]]);

endmodule

// File: src/diagReadback.sv
`timescale 1ns/1ns

module diagReadback #(
  parameter int selW  = conPkg::diagSelWidth,
  parameter int ebusW = conPkg::ebusDiagWidth
) (
  input  logic             diagReadFunc,
  input  logic [selW-1:0]  diagSel,
  input  logic             condLoadIr,
  input  logic             condSpecInstr,
  input  logic             condSrMagic,
  input  logic             condSelVma,
  input  logic             condDiagFunc,
  input  logic             condEbusCtl,
  input  logic             vmaMagic,
  input  logic             memCycle,
  input  logic             piCycle,
  input  logic             mboxWait,
  input  logic             kernelMode,
  input  logic             pxct,
  input  logic             run,
  input  logic             start,
  input  logic             cacheLookEn,
  input  logic             cacheLoadEn,
  input  logic             trapEn,
  input  logic             kiPagingMode,
  input  logic [2:0]       parWrBits,
  output logic [ebusW-1:0] ebusDiagOut,
  output logic             ebusDriving
);

  assign ebusDriving = diagReadFunc;

  // Bus bit 18 first
  always_comb begin
    ebusDiagOut = '0;
    if (diagReadFunc) begin
      case (diagSel)
        selW'(0): ebusDiagOut = {parWrBits, cacheLookEn, cacheLoadEn, kiPagingMode, trapEn};
        selW'(1): ebusDiagOut = {condLoadIr, condSpecInstr, condSrMagic, condSelVma,
                                 condDiagFunc, condEbusCtl, vmaMagic};
        selW'(2): ebusDiagOut = {run, start, memCycle, piCycle, kernelMode, pxct, mboxWait};
        default: ebusDiagOut = '0;
      endcase
    end
  end

endmodule

// File: src/conTop.sv
`timescale 1ns/1ns

module conTop #(
  parameter int condW  = conPkg::condWidth,
  parameter int magicW = conPkg::magicWidth,
  parameter int selW   = conPkg::diagSelWidth,
  parameter int ebusW  = conPkg::ebusDiagWidth
) (
  input  logic              conCLK,
  input  logic              CLK,
  input  logic [condW-1:0]  crCond,
  input  logic [magicW-1:0] crMagic,
  input  logic              mboxCycReq,
  input  logic              vmaFetch,
  input  logic              vmaAcRef,
  input  logic              mbXfer,
  input  logic              pageError,
  input  logic              skipSatisfied,
  input  logic              ebusSync,
  input  logic [ebusW-1:0]  ebusData,
  input  logic              diagCtlFunc01x,
  input  logic [selW-1:0]   diagDs,
  input  logic              diagReadFunc,
  input  logic [selW-1:0]   diagSel,
  input  logic              userMode,
  input  logic              publicMode,
  input  logic              userIot,
  input  logic              irIoLegal,
  input  logic              mtrIntReq,
  input  logic              piReady,
  output logic              conoApr,
  output logic              conoPi,
  output logic              conoPag,
  output logic              cacheLookEn,
  output logic              cacheLoadEn,
  output logic              trapEn,
  output logic              kiPagingMode,
  output logic [2:0]        parWrBits,
  output logic              memCycle,
  output logic              piCycle,
  output logic              mboxWait,
  output logic              loadIr,
  output logic              kernelMode,
  output logic              run,
  output logic              start,
  output logic              condAdr10,
  output logic [ebusW-1:0]  ebusDiagOut,
  output logic              ebusDriving
);

  logic condLoadIr;
  logic condSpecInstr;
  logic condSrMagic;
  logic condSelVma;
  logic condDiagFunc;
  logic condEbusCtl;
  logic vmaMagic;
  logic skipGroup6;
  logic skipGroup7;
  logic kernelCycle;
  logic pxct;
  logic intDisable;

  condDecode #(.condW(condW)) uCondDecode (.*);

  magicFuncDecode #(.magicW(magicW), .ebusW(ebusW)) uMagicFuncDecode (.*);

  cycleState #(.magicW(magicW)) uCycleState (.*);

  runControl #(.selW(selW)) uRunControl (.*);

  skipSelect #(.condW(condW)) uSkipSelect (.*);

  diagReadback #(.selW(selW), .ebusW(ebusW)) uDiagReadback (.*);

endmodule

// File: tests/con_assertions.sv
`timescale 1ns/1ns

module con_assertions (
  input logic       conCLK,
  input logic       CLK,
  input logic       conoApr,
  input logic       ebusSync,
  input logic [5:0] condStrobes,
  input logic       diagCtlFunc01x,
  input logic [2:0] diagDs,
  input logic       run
);

  aprNeedsSync: assert property (@(posedge conCLK) disable iff (CLK)
    conoApr |-> ebusSync)
    else $error("conoApr high while ebusSync is low");

  condOneHot: assert property (@(posedge conCLK) disable iff (CLK)
    $onehot0(condStrobes))
    else $error("more than one condition strobe active");

  // Three sync stages between strobe and run
  runRiseAfterSet: assert property (@(posedge conCLK) disable iff (CLK)
    $rose(run) |-> $past(diagCtlFunc01x && diagDs == 3'd1, 3))
    else $error("run rose without a set-run strobe three cycles before");

  runFallAfterClear: assert property (@(posedge conCLK) disable iff (CLK)
    $fell(run) |-> $past(diagCtlFunc01x && diagDs == 3'd0, 3))
    else $error("run fell without a clear-run strobe three cycles before");

endmodule

// File: tests/conChecker.sv
`timescale 1ns/1ns

module conChecker (
  input  logic                             conCLK,
  input  logic                             checkEn,
  input  int                               caseIdx,
  input  logic [11:0]                      expOut,
  input  logic [conPkg::ebusDiagWidth-1:0] expBus,
  input  logic                             diagReadFunc,
  input  logic [conPkg::diagSelWidth-1:0]  diagSel,
  input  logic                             loadIr,
  input  logic                             conoApr,
  input  logic                             conoPi,
  input  logic                             conoPag,
  input  logic                             cacheLookEn,
  input  logic                             cacheLoadEn,
  input  logic                             trapEn,
  input  logic                             kiPagingMode,
  input  logic [2:0]                       parWrBits,
  input  logic                             memCycle,
  input  logic                             piCycle,
  input  logic                             mboxWait,
  input  logic                             kernelMode,
  input  logic                             run,
  input  logic                             start,
  input  logic                             condAdr10,
  input  logic                             ebusDriving,
  input  logic [conPkg::ebusDiagWidth-1:0] ebusDiagOut,
  output int                               errCount,
  output int                               checkCount
);

  int          errors = 0;
  int          checks = 0;
  logic [11:0] gotOut;
  logic [2:0]  parWrSeen = 3'b000;
  logic        conoPiSeen = 1'b0;

  // Same bit order as the case file
  assign gotOut = {loadIr, conoApr, conoPag, cacheLookEn, cacheLoadEn, trapEn,
                   memCycle, mboxWait, run, start, condAdr10, ebusDriving};

  assign errCount   = errors;
  assign checkCount = checks;

  // Outputs settled by mid-cycle
  always @(negedge conCLK) begin
    if (checkEn) begin
      checks = checks + 1;
      if (gotOut !== expOut) begin
        errors = errors + 1;
        $display("FAIL %0t: case %0d status bits %03h, expected %03h",
                 $time, caseIdx, gotOut, expOut);
      end
      if (ebusDiagOut !== expBus) begin
        errors = errors + 1;
        $display("FAIL %0t: case %0d readback %02h, expected %02h",
                 $time, caseIdx, ebusDiagOut, expBus);
      end
      // Register ports against the readback word that shows them
      if (diagReadFunc && diagSel == 3'd0 &&
          {parWrBits, kiPagingMode} !== {expBus[6:4], expBus[1]}) begin
        errors = errors + 1;
        $display("FAIL %0t: case %0d parWrBits/kiPagingMode %h, expected %h",
                 $time, caseIdx, {parWrBits, kiPagingMode}, {expBus[6:4], expBus[1]});
      end
      if (diagReadFunc && diagSel == 3'd2 &&
          {piCycle, kernelMode} !== expBus[3:2]) begin
        errors = errors + 1;
        $display("FAIL %0t: case %0d piCycle/kernelMode %h, expected %h",
                 $time, caseIdx, {piCycle, kernelMode}, expBus[3:2]);
      end
      // Parity-write bits load only after a CONO PI
      if (parWrBits !== parWrSeen && !conoPiSeen) begin
        errors = errors + 1;
        $display("FAIL %0t: case %0d parWrBits changed to %h without conoPi",
                 $time, caseIdx, parWrBits);
      end
      conoPiSeen = conoPi;
      parWrSeen  = parWrBits;
    end
  end

endmodule

// File: tests/conTb.sv
`timescale 1ns/1ns

module conTb;

  localparam int fieldsPerCase = 8;
  localparam int maxCases      = 128;
  localparam int clkPeriod     = 40;

  logic                                conCLK = 1'b0;
  logic                                CLK;
  logic [conPkg::condWidth-1:0]        crCond;
  logic [conPkg::magicWidth-1:0]       crMagic;
  logic                                mboxCycReq;
  logic                                vmaFetch;
  logic                                vmaAcRef;
  logic                                mbXfer;
  logic                                pageError;
  logic                                skipSatisfied;
  logic                                ebusSync;
  logic [conPkg::ebusDiagWidth-1:0]    ebusData;
  logic                                diagCtlFunc01x;
  logic [conPkg::diagSelWidth-1:0]     diagDs;
  logic                                diagReadFunc;
  logic [conPkg::diagSelWidth-1:0]     diagSel;
  logic                                userMode;
  logic                                publicMode;
  logic                                userIot;
  logic                                irIoLegal;
  logic                                mtrIntReq;
  logic                                piReady;
  logic                                conoApr;
  logic                                conoPi;
  logic                                conoPag;
  logic                                cacheLookEn;
  logic                                cacheLoadEn;
  logic                                trapEn;
  logic                                kiPagingMode;
  logic [2:0]                          parWrBits;
  logic                                memCycle;
  logic                                piCycle;
  logic                                mboxWait;
  logic                                loadIr;
  logic                                kernelMode;
  logic                                run;
  logic                                start;
  logic                                condAdr10;
  logic [conPkg::ebusDiagWidth-1:0]    ebusDiagOut;
  logic                                ebusDriving;

  logic                                checkEn;
  int                                  caseIdx;
  logic [11:0]                         expOut;
  logic [conPkg::ebusDiagWidth-1:0]    expBus;
  int                                  errCount;
  int                                  checkCount;

  logic [15:0] caseMem [0:maxCases*fieldsPerCase-1];
  int          numCases;
  int          i;
  logic [31:0] randState;

  conTop dut (.*);

  conChecker conCheck (.*);

  always #(clkPeriod / 2) conCLK = ~conCLK;

  function automatic logic [31:0] nextRandom(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic applyCase(input int n);
    int base;
    base = n * fieldsPerCase;
    crCond  <= caseMem[base][5:0];
    crMagic <= caseMem[base+1][8:0];
    {mboxCycReq, vmaFetch, vmaAcRef, mbXfer, pageError, skipSatisfied}
      <= caseMem[base+2][5:0];
    {ebusSync, ebusData} <= caseMem[base+3][7:0];
    {diagCtlFunc01x, diagDs, diagReadFunc, diagSel} <= caseMem[base+4][7:0];
    {userMode, publicMode, mtrIntReq, piReady} <= caseMem[base+5][3:0];
    expOut  <= caseMem[base+6][11:0];
    expBus  <= caseMem[base+7][6:0];
    caseIdx <= n;
    checkEn <= 1'b1;
    // These only reach skip 7 entry 3, which no case selects
    randState = nextRandom(randState);
    {irIoLegal, userIot} <= randState[17:16];
  endtask

  initial begin
    CLK            = 1'b1;
    crCond         = '0;
    crMagic        = '0;
    mboxCycReq     = 1'b0;
    vmaFetch       = 1'b0;
    vmaAcRef       = 1'b0;
    mbXfer         = 1'b0;
    pageError      = 1'b0;
    skipSatisfied  = 1'b0;
    ebusSync       = 1'b0;
    ebusData       = '0;
    diagCtlFunc01x = 1'b0;
    diagDs         = '0;
    diagReadFunc   = 1'b0;
    diagSel        = '0;
    userMode       = 1'b0;
    publicMode     = 1'b0;
    userIot        = 1'b0;
    irIoLegal      = 1'b0;
    mtrIntReq      = 1'b0;
    piReady        = 1'b0;
    checkEn        = 1'b0;
    caseIdx        = 0;
    expOut         = '0;
    expBus         = '0;
    randState      = 32'd73;

    // Unused entries keep the end marker
    for (i = 0; i < maxCases * fieldsPerCase; i++) begin
      caseMem[i] = 16'hffff;
    end
    $readmemh("tests/conCases.txt", caseMem);
    numCases = 0;
    while (numCases < maxCases && caseMem[numCases * fieldsPerCase] != 16'hffff) begin
      numCases = numCases + 1;
    end

    repeat (2) @(posedge conCLK);
    CLK <= 1'b0;

    for (i = 0; i < numCases; i++) begin
      @(posedge conCLK);
      applyCase(i);
    end
    @(posedge conCLK);
    checkEn <= 1'b0;

    $display("Cases: %0d, checks: %0d, errors: %0d", numCases, checkCount, errCount);
    if (numCases > 0 && errCount == 0) begin
      $display("TEST OK");
    end else begin
      if (numCases == 0) begin
        $display("No cases were read from tests/conCases.txt");
      end
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog sized from the case count
  initial begin
    #1;
    #((numCases + 10) * clkPeriod);
    $display("Timeout: the run did not finish in the time allowed for its cases");
    $display("TEST FAILED");
    $finish;
  end

endmodule

bind conTop con_assertions conAsserts (
  .conCLK(conCLK),
  .CLK(CLK),
  .conoApr(conoApr),
  .ebusSync(ebusSync),
  .condStrobes({condLoadIr, condSpecInstr, condSrMagic, condSelVma,
                condDiagFunc, condEbusCtl}),
  .diagCtlFunc01x(diagCtlFunc01x),
  .diagDs(diagDs),
  .run(run)
);

// File: con.f
src/conPkg.sv
src/condDecode.sv
src/magicFuncDecode.sv
src/cycleState.sv
src/runControl.sv
src/skipSelect.sv
src/diagReadback.sv
src/conTop.sv
tests/con_assertions.sv
tests/conChecker.sv
tests/conTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module conTb -f con.f -o conSim

simOut=$(./obj_dir/conSim)
echo "$simOut"

if echo "$simOut" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

// File: tests/conCases.txt
// cond magic mem{req,fetch,acRef,xfer,pageErr,skipSat} ebus{sync,data[6:0]}
// diag{ctl01x,ds[2:0],readFunc,sel[2:0]} mode{user,public,mtrInt,piReady} expOut expBus
00 000 00 00 0A 0 001 04
0C 000 00 00 09 0 801 40
0D 000 00 00 09 0 001 20
0E 000 00 00 09 0 001 10
0F 000 00 00 09 0 001 08
10 000 00 00 09 0 001 04
12 000 00 00 09 0 001 02
18 000 00 00 09 0 001 00
00 000 00 00 09 0 001 01
// CONO PAG, then CONO APR with and without sync, then CONO PI
10 00E 00 64 08 0 201 00
00 000 00 00 08 0 1C1 0F
10 00C 00 00 08 0 1C1 0F
10 00C 00 80 08 0 5C1 0F
10 00D 00 D0 08 0 1C1 0F
00 000 00 00 08 0 1C1 5F
// Memory cycle
00 000 20 00 0A 0 1C1 04
00 000 00 00 0A 0 1F1 15
00 000 10 00 0A 0 9F1 15
00 000 08 00 0A 0 1E1 14
00 000 04 00 0A 0 1F1 15
00 000 00 00 0A 0 1C1 04
// Set run, continue, clear run
00 000 00 00 9A 0 1C1 04
00 000 00 00 0A 0 1C1 04
00 000 00 00 0A 0 1C1 04
00 000 00 00 0A 0 1C9 44
00 000 00 00 AA 0 1C9 44
00 000 00 00 0A 0 1C9 44
00 000 00 00 0A 0 1C9 44
00 000 00 00 0A 0 1CD 64
00 000 00 00 8A 0 1C9 44
00 000 00 00 0A 0 1C9 44
00 000 00 00 0A 0 1C9 44
00 000 00 00 0A 0 1C1 04
// Skip group 7 interrupt, masked by intDisable
38 000 00 00 00 2 1C0 00
38 000 00 00 00 2 1C2 00
38 000 00 00 00 0 1C2 00
38 000 00 00 00 0 1C0 00
0D 008 00 00 00 2 1C0 00
38 000 00 00 00 2 1C0 00
0D 000 00 00 00 2 1C0 00
38 000 00 00 00 2 1C2 00
// PI cycle and PXCT flags, kernel mode, skip group 6
0D 110 00 00 0A 0 1C1 04
00 000 00 00 0A 0 1C1 0E
00 000 01 00 0A 0 1C1 0E
00 000 00 00 0A 8 1C1 02
32 000 00 00 00 8 1C2 00
00 000 00 00 00 0 1C0 00
